// ==== cpu_control_pkg.sv ====
package cpu_control_pkg;

    // Debounce filter length, 20 us at 50 MHz
    localparam int DEBOUNCE_CYCLES = 1000;
    localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES + 1);

    // PLL model, reference clocks from reset release to lock
    localparam int LOCK_CYCLES = 64;
    localparam int LOCK_CNT_W  = $clog2(LOCK_CYCLES + 1);

    // System clocks that reset is held after lock
    localparam int RESET_HOLD_CYCLES = 16;
    localparam int HOLD_CNT_W        = $clog2(RESET_HOLD_CYCLES + 1);

    // Heartbeat half period, 0.2 s at 50 MHz
    localparam int                HB_PERIOD_W            = 32;
    localparam logic [31:0]       HEARTBEAT_HALF_DEFAULT = 32'd10_000_000;

    // Board widths
    localparam int LED_W      = 8;
    localparam int BUTTON_W   = 3;
    localparam int BIST_W     = 3;
    localparam int BIST_CNT_W = 8;

    // Wishbone bus widths
    localparam int WB_ADR_W = 2;
    localparam int WB_SEL_W = 8;
    localparam int WB_DAT_W = 32;
    localparam int WB_BYTES = WB_DAT_W / 8;

    // Register word addresses
    localparam logic [WB_ADR_W-1:0] REG_LED        = 2'd0;
    localparam logic [WB_ADR_W-1:0] REG_HB_HALF    = 2'd1;
    localparam logic [WB_ADR_W-1:0] REG_STATUS     = 2'd2;
    localparam logic [WB_ADR_W-1:0] REG_BIST_COUNT = 2'd3;

    // Master to slave, classic cycle
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_SEL_W-1:0] sel;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // Pressed bits, active high
    // Button 0 (start) sits in bit 0
    typedef struct packed {
        logic aux2;
        logic aux1;
        logic start;
    } user_buttons_t;

endpackage

// ==== debouncer.sv ====
`timescale 1ns/1ns

module debouncer
    import cpu_control_pkg::*;
#(
    parameter type sample_t = logic
)
(
    input  logic    clk_i,
    input  sample_t sig_i,
    output sample_t sig_o
);

    // Accepted level and count of differing samples
    // Power-up values only, the first stable stretch settles them
    sample_t                   accepted_q = sample_t'(0);
    logic [DEBOUNCE_CNT_W-1:0] diff_cnt_q = '0;

    logic differs;

    // Whole payload compared as one word
    assign differs = (sig_i != accepted_q);

    always_ff @(posedge clk_i)
    begin
        if (!differs)
        begin
            // Input back at accepted level, restart the filter
            diff_cnt_q <= '0;
        end
        else if (diff_cnt_q == DEBOUNCE_CNT_W'(DEBOUNCE_CYCLES))
        begin
            // Stable long enough, take the new level
            accepted_q <= sig_i;
            diff_cnt_q <= '0;
        end
        else
        begin
            diff_cnt_q <= diff_cnt_q + 1'b1;
        end
    end

    assign sig_o = accepted_q;

endmodule

// ==== clock_reset_gen.sv ====
`timescale 1ns/1ns

module clock_reset_gen
    import cpu_control_pkg::*;
(
    input  logic pll_refclk_i,
    input  logic pll_rst_i,
    output logic sys_clk_o,
    output logic pll_locked_o,
    output logic sys_rst_o
);

    // Lock counter starts at zero on configuration
    logic [LOCK_CNT_W-1:0] lock_cnt_q = '0;

    logic [HOLD_CNT_W-1:0] hold_cnt_q;
    logic                  hold_active;
    logic [1:0]            rst_sync_q;

    // No frequency change in this model
    assign sys_clk_o = pll_refclk_i;

    // Lock counter, held clear while the PLL is in reset
    always_ff @(posedge pll_refclk_i)
    begin
        if (pll_rst_i)
        begin
            lock_cnt_q <= '0;
        end
        else if (lock_cnt_q != LOCK_CNT_W'(LOCK_CYCLES))
        begin
            lock_cnt_q <= lock_cnt_q + 1'b1;
        end
    end

    // Saturated count means lock
    assign pll_locked_o = (lock_cnt_q == LOCK_CNT_W'(LOCK_CYCLES));

    // Reset stretch after lock
    always_ff @(posedge sys_clk_o)
    begin
        if (!pll_locked_o)
        begin
            hold_cnt_q <= '0;
        end
        else if (hold_active)
        begin
            hold_cnt_q <= hold_cnt_q + 1'b1;
        end
    end

    assign hold_active = (hold_cnt_q != HOLD_CNT_W'(RESET_HOLD_CYCLES));

    // Two-flop release synchroniser
    // Loaded with ones while lock is low
    always_ff @(posedge sys_clk_o)
    begin
        if (!pll_locked_o)
        begin
            rst_sync_q <= 2'b11;
        end
        else
        begin
            rst_sync_q <= {rst_sync_q[0], hold_active};
        end
    end

    // Loss of lock asserts reset at once, release goes through the flops
    assign sys_rst_o = rst_sync_q[1] | ~pll_locked_o;

endmodule

// ==== edge_detector.sv ====
`timescale 1ns/1ns

module edge_detector
(
    input  logic clk_i,
    input  logic rst_i,
    input  logic signal_i,
    output logic rise_detected_o,
    output logic fall_detected_o
);

    // Previous level of the input
    logic prev_q;
    logic rise_q;
    logic fall_q;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            prev_q <= 1'b0;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end
        else
        begin
            prev_q <= signal_i;
            // Registered pulses, one cycle wide
            rise_q <= signal_i & ~prev_q;
            fall_q <= ~signal_i & prev_q;
        end
    end

    assign rise_detected_o = rise_q;
    assign fall_detected_o = fall_q;

endmodule

// ==== heartbeat_gen.sv ====
`timescale 1ns/1ns

module heartbeat_gen
    import cpu_control_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [HB_PERIOD_W-1:0] half_period_i,
    output logic                   heartbeat_o
);

    logic [HB_PERIOD_W-1:0] count_q;
    logic                   beat_q;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            count_q <= '0;
            beat_q  <= 1'b0;
        end
        // At or above, so a shorter period cuts the current count short
        else if (count_q >= half_period_i)
        begin
            count_q <= '0;
            beat_q  <= ~beat_q;
        end
        else
        begin
            count_q <= count_q + 1'b1;
        end
    end

    // Toggles are half_period_i + 1 cycles apart
    assign heartbeat_o = beat_q;

endmodule

// ==== control_regs.sv ====
`timescale 1ns/1ns

module control_regs
    import cpu_control_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  wb_req_t                wb_req_i,
    output wb_rsp_t                wb_rsp_o,
    input  user_buttons_t          buttons_i,
    input  logic                   bist_start_i,
    input  logic [BIST_W-1:0]      bist_status_i,
    input  logic                   heartbeat_i,
    output logic [LED_W-1:0]       led_o,
    output logic [HB_PERIOD_W-1:0] hb_half_o
);

    logic [LED_W-1:0]       led_q;
    logic [HB_PERIOD_W-1:0] hb_half_q;
    logic [BIST_CNT_W-1:0]  bist_cnt_q;
    logic                   ack_q;
    logic [WB_DAT_W-1:0]    rd_dat_q;

    logic                   req_valid;
    logic                   wr_en;
    logic [WB_DAT_W-1:0]    rd_mux;

    // Byte lane merge of write data into the old register value
    function automatic logic [WB_DAT_W-1:0] merge_bytes(
        input logic [WB_DAT_W-1:0] old_v,
        input logic [WB_DAT_W-1:0] new_v,
        input logic [WB_SEL_W-1:0] sel
    );
        logic [WB_DAT_W-1:0] res;
        res = old_v;
        for (int i = 0; i < WB_BYTES; i++)
        begin
            if (sel[i])
            begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    // New request, ack not yet given
    assign req_valid = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign wr_en     = req_valid & wb_req_i.we;

    // Read data selection
    always_comb
    begin
        rd_mux = '0;
        case (wb_req_i.adr)
            REG_LED:        rd_mux = WB_DAT_W'(led_q);
            REG_HB_HALF:    rd_mux = WB_DAT_W'(hb_half_q);
            // Buttons, then BIST status, then heartbeat
            REG_STATUS:     rd_mux = WB_DAT_W'({heartbeat_i, bist_status_i, buttons_i});
            REG_BIST_COUNT: rd_mux = WB_DAT_W'(bist_cnt_q);
            default:        rd_mux = '0;
        endcase
    end

    // Bus handshake and read data, one wait cycle
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            ack_q    <= 1'b0;
            rd_dat_q <= '0;
        end
        else
        begin
            ack_q <= req_valid;
            if (req_valid)
            begin
                rd_dat_q <= rd_mux;
            end
        end
    end

    // Writable registers, visible on the ack cycle
    // Writes to status and BIST count fall through
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            led_q     <= '0;
            hb_half_q <= HEARTBEAT_HALF_DEFAULT;
        end
        else if (wr_en && wb_req_i.adr == REG_LED)
        begin
            led_q <= LED_W'(merge_bytes(WB_DAT_W'(led_q), wb_req_i.dat, wb_req_i.sel));
        end
        else if (wr_en && wb_req_i.adr == REG_HB_HALF)
        begin
            hb_half_q <= merge_bytes(hb_half_q, wb_req_i.dat, wb_req_i.sel);
        end
    end

    // BIST start counter, wraps
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            bist_cnt_q <= '0;
        end
        else if (bist_start_i)
        begin
            bist_cnt_q <= bist_cnt_q + 1'b1;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_dat_q;
    assign led_o        = led_q;
    assign hb_half_o    = hb_half_q;

endmodule

// ==== cpu_control.sv ====
`timescale 1ns/1ns

module cpu_control
    import cpu_control_pkg::*;
(
    input  logic                pll_refclk_i,
    input  logic                rst_button_i,
    input  logic [BUTTON_W-1:0] user_button_n_i,
    input  logic [BIST_W-1:0]   bist_status_i,
    input  wb_req_t             wb_req_i,
    output logic                clk_o,
    output logic                rst_o,
    output logic                pll_locked_o,
    output logic                heartbeat_o,
    output logic                bist_start_o,
    output logic [LED_W-1:0]    led_o,
    output wb_rsp_t             wb_rsp_o
);

    logic                   rst_button_db;
    user_buttons_t          buttons_raw;
    user_buttons_t          buttons_db;
    logic [HB_PERIOD_W-1:0] hb_half;

    // Reset button, filtered on the reference clock
    debouncer #(.sample_t(logic)) reset_button (
        .clk_i (pll_refclk_i),
        .sig_i (rst_button_i),
        .sig_o (rst_button_db)
    );

    // Button pressed holds the PLL model in reset
    clock_reset_gen clock_reset_gen (
        .pll_refclk_i (pll_refclk_i),
        .pll_rst_i    (~rst_button_db),
        .sys_clk_o    (clk_o),
        .pll_locked_o (pll_locked_o),
        .sys_rst_o    (rst_o)
    );

    // Active-low pins to pressed bits
    assign buttons_raw = user_buttons_t'(~user_button_n_i);

    debouncer #(.sample_t(user_buttons_t)) user_buttons (
        .clk_i (clk_o),
        .sig_i (buttons_raw),
        .sig_o (buttons_db)
    );

    // Press of button 0 starts BIST
    edge_detector start_command (
        .clk_i           (clk_o),
        .rst_i           (rst_o),
        .signal_i        (buttons_db.start),
        .rise_detected_o (bist_start_o),
        .fall_detected_o ()
    );

    heartbeat_gen heartbeat_gen (
        .clk_i         (clk_o),
        .rst_i         (rst_o),
        .half_period_i (hb_half),
        .heartbeat_o   (heartbeat_o)
    );

    control_regs control_regs (
        .clk_i         (clk_o),
        .rst_i         (rst_o),
        .wb_req_i      (wb_req_i),
        .wb_rsp_o      (wb_rsp_o),
        .buttons_i     (buttons_db),
        .bist_start_i  (bist_start_o),
        .bist_status_i (bist_status_i),
        .heartbeat_i   (heartbeat_o),
        .led_o         (led_o),
        .hb_half_o     (hb_half)
    );

endmodule

// ==== tb_cpu_control.sv ====
`timescale 1ns/1ns

module tb_cpu_control
    import cpu_control_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int TEST_COUNT  = 5;
    localparam int HOLD_CYCLES = DEBOUNCE_CYCLES + 20;
    localparam int ACK_LIMIT   = 16;
    localparam int LOCK_LIMIT  = DEBOUNCE_CYCLES + LOCK_CYCLES + 200;
    // Four filter-plus-lock stretches per test, then a margin
    localparam int WATCHDOG_CYCLES = TEST_COUNT * 4 * LOCK_LIMIT + 1000;

    logic                pll_refclk_i = 1'b0;
    logic                rst_button_i;
    logic [BUTTON_W-1:0] user_button_n_i;
    logic [BIST_W-1:0]   bist_status_i;
    wb_req_t             wb_req_i;
    logic                clk_o;
    logic                rst_o;
    logic                pll_locked_o;
    logic                heartbeat_o;
    logic                bist_start_o;
    logic [LED_W-1:0]    led_o;
    wb_rsp_t             wb_rsp_o;
    logic [31:0]         lcg_state;

    // Port names match the local signals
    cpu_control uut (.*);

    always #(CLK_PERIOD / 2) pll_refclk_i = ~pll_refclk_i;

    // Numerical Recipes constants
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_with(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("FAIL at %0t ns: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // One classic cycle, request held until ack
    task automatic wb_transfer(input logic we, input logic [WB_ADR_W-1:0] adr,
                               input logic [31:0] wdata, input logic [WB_SEL_W-1:0] sel,
                               output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(posedge pll_refclk_i);
        wb_req_i <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: wdata};
        @(negedge pll_refclk_i);
        while (!wb_rsp_o.ack)
        begin
            if (waited == ACK_LIMIT)
                fail_with("Wishbone slave never raised ack");
            waited++;
            @(negedge pll_refclk_i);
        end
        // Read data valid together with ack
        rdata = wb_rsp_o.dat;
        @(posedge pll_refclk_i);
        wb_req_i <= '0;
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [31:0] wdata,
                            input logic [WB_SEL_W-1:0] sel);
        logic [31:0] ignored_data;
        wb_transfer(1'b1, adr, wdata, sel, ignored_data);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [31:0] rdata);
        wb_transfer(1'b0, adr, 32'h0, '0, rdata);
    endtask

    task automatic read_expect(input logic [WB_ADR_W-1:0] adr, input logic [31:0] expected,
                               input string what);
        logic [31:0] data;
        wb_read(adr, data);
        check_value(what, data, expected);
    endtask

    // bist_start pulses seen over a window
    task automatic count_pulses(input int cycles, output int pulses);
        pulses = 0;
        repeat (cycles)
        begin
            @(negedge pll_refclk_i);
            if (bist_start_o)
                pulses++;
        end
    endtask

    task automatic hold_buttons(input logic [BUTTON_W-1:0] level_n, input int cycles,
                                output int pulses);
        @(posedge pll_refclk_i);
        user_button_n_i <= level_n;
        count_pulses(cycles, pulses);
    endtask

    // Cycles until the heartbeat level changes
    task automatic measure_toggle(output int cycles);
        logic start_level;
        start_level = heartbeat_o;
        cycles = 0;
        do
        begin
            @(negedge pll_refclk_i);
            cycles++;
            if (cycles > 100)
                fail_with("heartbeat stopped toggling");
        end
        while (heartbeat_o == start_level);
    endtask

    // System clock follows the reference clock in both phases
    task automatic clock_passthrough();
        repeat (4)
        begin
            @(posedge pll_refclk_i);
            #(CLK_PERIOD / 4);
            check_value("clk_o in high phase", 32'(clk_o), 32'd1);
            @(negedge pll_refclk_i);
            #(CLK_PERIOD / 4);
            check_value("clk_o in low phase", 32'(clk_o), 32'd0);
        end
    endtask

    // Lock first, release hold count plus two sync flops later
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(negedge pll_refclk_i);
        while (!pll_locked_o)
        begin
            if (cycles == LOCK_LIMIT)
                fail_with("PLL model never reported lock");
            cycles++;
            @(negedge pll_refclk_i);
        end
        check_value("rst_o at lock", 32'(rst_o), 32'd1);
        cycles = 0;
        while (rst_o)
        begin
            if (cycles == RESET_HOLD_CYCLES + 10)
                fail_with("system reset never released");
            cycles++;
            @(negedge pll_refclk_i);
        end
        check_value("cycles from lock to reset release", cycles, RESET_HOLD_CYCLES + 2);
    endtask

    task automatic power_up_sequence();
        wait_reset_release();
        check_value("led_o after reset", 32'(led_o), 32'h0);
        check_value("bist_start_o after reset", 32'(bist_start_o), 32'h0);
        read_expect(REG_LED, 32'h0, "LED register after reset");
        read_expect(REG_HB_HALF, HEARTBEAT_HALF_DEFAULT, "half period after reset");
        read_expect(REG_BIST_COUNT, 32'h0, "BIST count after reset");
        clock_passthrough();
    endtask

    task automatic register_access();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] status;
        repeat (4)
        begin
            a = next_random();
            wb_write(REG_LED, a, '1);
            @(negedge pll_refclk_i);
            check_value("led_o after full write", 32'(led_o), 32'(a[7:0]));
            read_expect(REG_LED, 32'(a[7:0]), "LED readback");
        end
        // Lane 0 deselected so the LEDs hold
        wb_write(REG_LED, next_random(), 8'hFE);
        read_expect(REG_LED, 32'(a[7:0]), "LED after masked write");
        // Lanes 0 and 2 only
        b = next_random();
        wb_write(REG_HB_HALF, a, '1);
        wb_write(REG_HB_HALF, b, 8'h05);
        read_expect(REG_HB_HALF, {a[31:24], b[23:16], a[15:8], b[7:0]}, "half period merge");
        wb_write(REG_HB_HALF, HEARTBEAT_HALF_DEFAULT, '1);
        // Status is read only
        wb_read(REG_STATUS, status);
        wb_write(REG_STATUS, next_random(), '1);
        read_expect(REG_STATUS, status, "status after write");
    endtask

    task automatic heartbeat_period();
        int cycles;
        wb_write(REG_HB_HALF, 32'd9, '1);
        @(negedge pll_refclk_i);
        // First interval may carry the old count
        measure_toggle(cycles);
        measure_toggle(cycles);
        measure_toggle(cycles);
        check_value("cycles between heartbeat toggles", cycles, 9 + 1);
        wb_write(REG_HB_HALF, HEARTBEAT_HALF_DEFAULT, '1);
    endtask

    task automatic button_to_bist();
        int          pulses;
        int          tail_pulses;
        logic [31:0] rnd;
        logic [31:0] status;
        hold_buttons(3'b110, HOLD_CYCLES, pulses);
        check_value("BIST start pulses on press", pulses, 1);
        hold_buttons(3'b111, HOLD_CYCLES, pulses);
        check_value("BIST start pulses on release", pulses, 0);
        read_expect(REG_BIST_COUNT, 32'd1, "BIST count after one press");
        // Short glitch on button 0
        hold_buttons(3'b110, 5, pulses);
        hold_buttons(3'b111, HOLD_CYCLES, tail_pulses);
        check_value("BIST start pulses after glitch", pulses + tail_pulses, 0);
        rnd = next_random();
        @(posedge pll_refclk_i);
        bist_status_i <= rnd[BIST_W-1:0];
        // Aux buttons pressed, start released
        hold_buttons(3'b001, HOLD_CYCLES, pulses);
        check_value("BIST start pulses with aux buttons", pulses, 0);
        // Heartbeat bit masked off
        wb_read(REG_STATUS, status);
        check_value("status with aux buttons", status & 32'h3F,
                    32'({rnd[BIST_W-1:0], 3'b110}));
        hold_buttons(3'b111, HOLD_CYCLES, pulses);
        wb_read(REG_STATUS, status);
        check_value("status after release", status & 32'h3F, 32'({rnd[BIST_W-1:0], 3'b000}));
    endtask

    task automatic reset_button_recovery();
        wb_write(REG_LED, 32'h0000_00A5, '1);
        @(posedge pll_refclk_i);
        rst_button_i <= 1'b0;
        repeat (HOLD_CYCLES)
            @(negedge pll_refclk_i);
        check_value("pll_locked_o while button held", 32'(pll_locked_o), 32'd0);
        check_value("rst_o while button held", 32'(rst_o), 32'd1);
        check_value("led_o in reset", 32'(led_o), 32'h0);
        check_value("heartbeat_o in reset", 32'(heartbeat_o), 32'h0);
        check_value("bist_start_o in reset", 32'(bist_start_o), 32'h0);
        @(posedge pll_refclk_i);
        rst_button_i <= 1'b1;
        wait_reset_release();
        check_value("led_o after recovery", 32'(led_o), 32'h0);
        read_expect(REG_LED, 32'h0, "LED register after recovery");
        read_expect(REG_BIST_COUNT, 32'h0, "BIST count after recovery");
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial
    begin
        rst_button_i    <= 1'b0;
        user_button_n_i <= '1;
        bist_status_i   <= '0;
        wb_req_i        <= '0;
        lcg_state = 32'd17;
        // Reset button pressed for the first cycles
        repeat (3)
            @(posedge pll_refclk_i);
        rst_button_i <= 1'b1;
        power_up_sequence();
        register_access();
        heartbeat_period();
        button_to_bist();
        reset_button_recovery();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== cpu_control.f ====
cpu_control_pkg.sv
debouncer.sv
clock_reset_gen.sv
edge_detector.sv
heartbeat_gen.sv
control_regs.sv
cpu_control.sv
tb_cpu_control.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing
TOP       := tb_cpu_control
RTL_TOP   := cpu_control
FILELIST  := cpu_control.f
BUILD_DIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator's exit status carries pass or fail
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
